//--- flist.f
+incdir+include
source/agen_pkg.sv
source/reg_size_selector.sv
source/dest_operand_gen.sv
source/src_operand_gen.sv
source/agen_pipe_stage.sv
source/address_generation_top.sv
tb/address_generation_tb.sv

//--- run.sh
#!/bin/sh
# build and run the address generation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f \
    --top-module address_generation_tb -o address_generation_tb
./obj_dir/address_generation_tb > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- include/agen_tb_model.svh
/*
 * Expected-value model of the address generation stage.
 * Include inside a module after agen_pkg is compiled.
 */
`ifndef AGEN_TB_MODEL_SVH
`define AGEN_TB_MODEL_SVH

// size view of register n with high bytes for byte numbers 4..7
function automatic logic [63:0] size_view(agen_pkg::reg_snapshot_t regs,
                                          logic [2:0] size, logic [2:0] n);
    case (size)
        3'd1:    return n[2] ? 64'(regs.gpr[n[1:0]][15:8]) : 64'(regs.gpr[n[1:0]][7:0]);
        3'd2:    return 64'(regs.gpr[n][15:0]);
        3'd3:    return 64'(regs.gpr[n]);
        3'd5:    return regs.mm[n];
        default: return 64'd0;
    endcase
endfunction

function automatic logic [15:0] segment_value(agen_pkg::reg_snapshot_t regs, logic [2:0] idx);
    logic [15:0] segs [8];
    segs = '{regs.es, regs.cs, regs.ss, regs.ds, regs.fs, regs.gs, 16'd0, 16'd0};
    return segs[idx];
endfunction

// kind value before any string or pop handling
function automatic logic [63:0] operand_for_kind(agen_pkg::instr_ctrl_t ctrl,
                                                 agen_pkg::reg_snapshot_t regs,
                                                 logic [2:0] kind, logic [2:0] n,
                                                 logic [31:0] mem_addr);
    case (kind)
        3'd1:    return size_view(regs, ctrl.size, n);
        3'd2:    return 64'(segment_value(regs, n));
        3'd3:    return regs.mm[n];
        3'd5:    return 64'(ctrl.imm);
        3'd6:    return 64'(mem_addr);
        default: return 64'd0;
    endcase
endfunction

function automatic agen_pkg::agen_out_t expected_out(agen_pkg::instr_ctrl_t ctrl,
                                                     agen_pkg::reg_snapshot_t regs);
    agen_pkg::agen_out_t res;
    logic [15:0] src_seg;
    logic [31:0] es_edi;
    logic [31:0] src_esi;
    logic        pop;
    src_seg = ctrl.seg_override_valid ? segment_value(regs, ctrl.seg_override) : regs.ds;
    es_edi  = 32'(regs.es) * 32'd16 + regs.gpr[7];
    src_esi = 32'(src_seg) * 32'd16 + regs.gpr[6];
    pop     = ctrl.stack_op[1];
    res = '0;
    res.size          = ctrl.size;
    res.set_d_flag    = ctrl.set_d_flag;
    res.clear_d_flag  = ctrl.clear_d_flag;
    res.op0_reg       = ctrl.op0_reg;
    res.op1_reg       = ctrl.op1_reg;
    res.imm           = ctrl.imm;
    res.alu_op        = ctrl.alu_op;
    res.flag_0        = ctrl.flag_0;
    res.flag_1        = ctrl.flag_1;
    res.stack_op      = ctrl.stack_op;
    res.stack_address = ctrl.stack_address;
    res.pc            = ctrl.pc;
    res.branch_taken  = ctrl.branch_taken;
    res.opcode        = ctrl.opcode;
    res.op0.value      = operand_for_kind(ctrl, regs, ctrl.op0, ctrl.op0_reg, es_edi);
    res.op0.is_reg     = (ctrl.op0 == 3'd1);
    res.op0.is_segment = (ctrl.op0 == 3'd2);
    res.op0.is_mmx     = (ctrl.size == 3'd5);
    res.op1.value      = pop ? 64'(ctrl.stack_address)
                             : operand_for_kind(ctrl, regs, ctrl.op1, ctrl.op1_reg, src_esi);
    res.op1.is_reg     = (ctrl.op1 == 3'd1);
    res.op1.is_address = (ctrl.op1 == 3'd6) || pop;
    res.to_sys_controller = (ctrl.op0 == 3'd7);
    return res;
endfunction

`endif

//--- tb/address_generation_tb.sv
/*
 * Random and directed stimulus for the address generation stage.
 * Expected outputs come from agen_tb_model.svh; queue order is the transfer order.
 */
`timescale 1ns/100ps

module address_generation_tb;
    import agen_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_ITEMS       = 92;
    localparam int WATCHDOG_CYCLES = NUM_ITEMS * 20 + 100;
    localparam int CTRL_W          = $bits(instr_ctrl_t);
    localparam int REGS_W          = $bits(reg_snapshot_t);

    logic          clk;
    logic          rst;
    logic          flush;
    logic          r_valid;
    logic          r_ready;
    instr_ctrl_t   r_ctrl;
    reg_snapshot_t r_regs;
    logic          a_valid;
    logic          a_ready;
    agen_out_t     a_out;

    // scoreboard
    agen_out_t exp_q [$];
    string     name_q [$];
    string     cur_name;
    int        errors;
    int        transfers;
    int        ready_mode;
    logic      rst_d;
    logic      flush_d;
    logic      stall_d;
    logic      load_d;
    agen_out_t out_d;

    string test_names [5] = '{"reg_views", "operand_kinds", "string_mem", "stack_pop",
                              "backpressure"};
    int    test_counts [5] = '{24, 16, 12, 8, 30};

    `include "agen_tb_model.svh"

    address_generation_top address_generation_top_inst (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_ctrl  (r_ctrl),
        .r_regs  (r_regs),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_out   (a_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [1023:0] rand_vec();
        logic [1023:0] v;
        for (int i = 0; i < 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic reg_snapshot_t rand_regs();
        return REGS_W'(rand_vec());
    endfunction

    // random fields, then the ones that define each test
    function automatic instr_ctrl_t test_ctrl(int test, int i);
        instr_ctrl_t c;
        c = CTRL_W'(rand_vec());
        c.stack_op[1] = 1'b0;
        case (test)
            0: begin
                c.op0  = OP_REG;
                c.op1  = OP_REG;
                c.size = op_size_t'(3'(i));
            end
            1: begin
                c.op0 = op_kind_t'(3'(i));
                c.op1 = op_kind_t'(3'(i + 3));
            end
            2: begin
                c.op0 = OP_MEM;
                c.op1 = OP_MEM;
            end
            3: c.stack_op[1] = 1'b1;
            default: c.stack_op = 2'($urandom);
        endcase
        return c;
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic report_mismatch(input string name, input agen_out_t exp, input agen_out_t act);
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_item(input string name, input instr_ctrl_t ctrl,
                             input reg_snapshot_t regs);
        cur_name = name;
        r_ctrl   = ctrl;
        r_regs   = regs;
        r_valid  = 1'b1;
        @(posedge clk);
        while (!r_ready) @(posedge clk);
        #2;
        r_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) idle_cycles(1);
    endtask

    // a_ready follows the mode seen at the edge
    initial begin
        int mode;
        a_ready = 1'b0;
        forever begin
            @(posedge clk);
            mode = ready_mode;
            #2;
            a_ready = (mode == 0) ? 1'b1 : (mode == 1) ? 1'($urandom) : 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            name_q.delete();
        end else begin
            assert (!(rst_d && a_valid)) else report_failure("a_valid high after reset");
            assert (!(flush_d && a_valid)) else report_failure("a_valid high after a flush");
            assert (r_ready == ((!a_valid || a_ready) && !flush))
                else report_failure("r_ready does not follow a_valid, a_ready and flush");
            if (load_d) begin
                assert (a_valid)
                    else report_failure("accepted input not on a_out one cycle later");
            end
            if (stall_d) begin
                assert (a_valid && a_out == out_d)
                    else report_failure("a_valid or a_out changed while stalled");
            end
            if (flush) begin
                exp_q.delete();
                name_q.delete();
            end else begin
                if (a_valid && a_ready) begin
                    assert (exp_q.size() != 0)
                        else report_failure("output transfer with no accepted input");
                    if (exp_q.size() != 0) begin
                        assert (a_out == exp_q[0])
                            else report_mismatch(name_q[0], exp_q[0], a_out);
                        void'(exp_q.pop_front());
                        void'(name_q.pop_front());
                        transfers++;
                    end
                end
                if (r_valid && r_ready) begin
                    exp_q.push_back(expected_out(r_ctrl, r_regs));
                    name_q.push_back(cur_name);
                end
            end
        end
        rst_d   = rst;
        flush_d = flush;
        stall_d = a_valid && !a_ready && !rst && !flush;
        load_d  = r_valid && r_ready && !rst && !flush;
        out_d   = a_out;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped passing items",
                 WATCHDOG_CYCLES);
        $display("transfers checked: %0d, errors: %0d", transfers, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'h5246));
        rst        = 1'b1;
        flush      = 1'b0;
        r_valid    = 1'b0;
        r_ctrl     = '0;
        r_regs     = '0;
        cur_name   = "";
        errors     = 0;
        transfers  = 0;
        ready_mode = 0;
        rst_d      = 1'b0;
        flush_d    = 1'b0;
        stall_d    = 1'b0;
        load_d     = 1'b0;
        out_d      = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int t = 0; t < 5; t++) begin
            ready_mode = (t == 4) ? 1 : 0;
            for (int i = 0; i < test_counts[t]; i++) begin
                if (t == 4) idle_cycles($urandom % 3);
                send_item(test_names[t], test_ctrl(t, i), rand_regs());
            end
        end

        // hold one item, flush it while a new input waits
        ready_mode = 0;
        wait_drained();
        ready_mode = 2;
        idle_cycles(1);
        send_item("flush_held", test_ctrl(4, 0), rand_regs());
        flush    = 1'b1;
        cur_name = "flush_blocked";
        r_ctrl   = test_ctrl(4, 1);
        r_valid  = 1'b1;
        idle_cycles(1);
        flush      = 1'b0;
        r_valid    = 1'b0;
        ready_mode = 0;
        send_item("flush_resume", test_ctrl(4, 2), rand_regs());
        wait_drained();
        idle_cycles(2);

        $display("transfers checked: %0d, errors: %0d", transfers, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- source/address_generation_top.sv
/*
 * Address generation stage: both operand generators share one size
 * selector and feed a single register stage toward the memory stage.
 */
`timescale 1ns/100ps

module address_generation_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,

    // from register read
    input  logic                    r_valid,
    output logic                    r_ready,
    input  agen_pkg::instr_ctrl_t   r_ctrl,
    input  agen_pkg::reg_snapshot_t r_regs,

    // to memory stage
    output logic                    a_valid,
    input  logic                    a_ready,
    output agen_pkg::agen_out_t     a_out
);
    import agen_pkg::*;

    sized_regs_t sized;
    op_result_t  op0;
    op_result_t  op1;

    reg_size_selector reg_size_selector_inst (
        .size  (r_ctrl.size),
        .regs  (r_regs),
        .sized (sized)
    );

    dest_operand_gen dest_operand_gen_inst (
        .ctrl  (r_ctrl),
        .regs  (r_regs),
        .sized (sized),
        .op0   (op0)
    );

    src_operand_gen src_operand_gen_inst (
        .ctrl  (r_ctrl),
        .regs  (r_regs),
        .sized (sized),
        .op1   (op1)
    );

    agen_pipe_stage agen_pipe_stage_inst (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .ctrl    (r_ctrl),
        .op0     (op0),
        .op1     (op1),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_out   (a_out)
    );

endmodule

//--- source/agen_pipe_stage.sv
/*
 * Single-entry output register with valid/ready flow control.
 * Passes one item per cycle; flush drops the held item and blocks
 * acceptance in the same cycle.
 */
`timescale 1ns/100ps

module agen_pipe_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  agen_pkg::instr_ctrl_t ctrl,
    input  agen_pkg::op_result_t  op0,
    input  agen_pkg::op_result_t  op1,
    output logic                  a_valid,
    input  logic                  a_ready,
    output agen_pkg::agen_out_t   a_out
);
    import agen_pkg::*;

    agen_out_t next_out;
    logic      load;

    assign next_out = '{
        size:              ctrl.size,
        set_d_flag:        ctrl.set_d_flag,
        clear_d_flag:      ctrl.clear_d_flag,
        op0_reg:           ctrl.op0_reg,
        op1_reg:           ctrl.op1_reg,
        imm:               ctrl.imm,
        alu_op:            ctrl.alu_op,
        flag_0:            ctrl.flag_0,
        flag_1:            ctrl.flag_1,
        stack_op:          ctrl.stack_op,
        stack_address:     ctrl.stack_address,
        pc:                ctrl.pc,
        branch_taken:      ctrl.branch_taken,
        opcode:            ctrl.opcode,
        op0:               op0,
        op1:               op1,
        to_sys_controller: (ctrl.op0 == OP_SYS)
    };

    // room when empty or when the held item leaves this cycle
    assign r_ready = (!a_valid || a_ready) && !flush;
    assign load    = r_valid && r_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            a_valid <= 1'b0;
        end else if (r_ready) begin
            a_valid <= r_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_out <= next_out;
        end
    end

endmodule

//--- source/src_operand_gen.sv
/*
 * Source operand (op1) and its flags, purely combinational.
 * Memory kind is DS:ESI unless a segment override is valid.
 * A pop replaces the value with the stack address, whatever the kind.
 */
`timescale 1ns/100ps

module src_operand_gen (
    input  agen_pkg::instr_ctrl_t   ctrl,
    input  agen_pkg::reg_snapshot_t regs,
    input  agen_pkg::sized_regs_t   sized,
    output agen_pkg::op_result_t    op1
);
    import agen_pkg::*;

    seg_t     mem_seg;
    addr_t    string_addr;
    operand_t kind_value;
    operand_t value;
    logic     is_pop;

    assign is_pop = ctrl.stack_op[1];

    // DS unless a valid override names the segment
    assign mem_seg = ctrl.seg_override_valid ? seg_select(regs, ctrl.seg_override)
                                             : regs.ds;
    assign string_addr = real_mode_addr(mem_seg, regs.gpr[REG_ESI]);

    always_comb begin
        case (ctrl.op1)
            OP_REG:  kind_value = sized[ctrl.op1_reg];
            OP_SEG:  kind_value = operand_t'(seg_select(regs, seg_idx_t'(ctrl.op1_reg)));
            OP_MMX:  kind_value = regs.mm[ctrl.op1_reg];
            OP_IMM:  kind_value = operand_t'(ctrl.imm);
            OP_MEM:  kind_value = operand_t'(string_addr);
            default: kind_value = '0;
        endcase
    end

    // pops read from the top of stack
    assign value = is_pop ? operand_t'(ctrl.stack_address) : kind_value;

    assign op1 = '{
        value:      value,
        is_reg:     (ctrl.op1 == OP_REG),
        is_segment: 1'b0,
        is_mmx:     1'b0,
        is_address: (ctrl.op1 == OP_MEM) || is_pop
    };

endmodule

//--- source/dest_operand_gen.sv
/*
 * Destination operand (op0) and its flags, purely combinational.
 * Memory kind is always ES:EDI, no override; mod r/m kind gives zero.
 */
`timescale 1ns/100ps

module dest_operand_gen (
    input  agen_pkg::instr_ctrl_t   ctrl,
    input  agen_pkg::reg_snapshot_t regs,
    input  agen_pkg::sized_regs_t   sized,
    output agen_pkg::op_result_t    op0
);
    import agen_pkg::*;

    operand_t value;
    addr_t    string_addr;

    // string destination
    assign string_addr = real_mode_addr(regs.es, regs.gpr[REG_EDI]);

    always_comb begin
        case (ctrl.op0)
            OP_REG:  value = sized[ctrl.op0_reg];
            OP_SEG:  value = operand_t'(seg_select(regs, seg_idx_t'(ctrl.op0_reg)));
            OP_MMX:  value = regs.mm[ctrl.op0_reg];
            OP_IMM:  value = operand_t'(ctrl.imm);
            OP_MEM:  value = operand_t'(string_addr);
            // none, modrm and sys
            default: value = '0;
        endcase
    end

    // op0 is never read from memory here
    assign op0 = '{
        value:      value,
        is_reg:     (ctrl.op0 == OP_REG),
        is_segment: (ctrl.op0 == OP_SEG),
        is_mmx:     (ctrl.size == SIZE_MMX),
        is_address: 1'b0
    };

endmodule

//--- source/reg_size_selector.sv
/*
 * Size views of the register snapshot, all zero-extended to 64 bits.
 * Byte size maps numbers 4 to 7 onto AH, CH, DH and BH.
 */
`timescale 1ns/100ps

module reg_size_selector (
    input  agen_pkg::op_size_t      size,
    input  agen_pkg::reg_snapshot_t regs,
    output agen_pkg::sized_regs_t   sized
);
    import agen_pkg::*;

    always_comb begin
        for (int n = 0; n < NUM_REGS; n++) begin
            case (size)
                // low bytes for 0..3 and bits 15:8 of the same four for 4..7
                SIZE_BYTE:  sized[n] = operand_t'(regs.gpr[n % 4][(n / 4) * 8 +: 8]);
                SIZE_WORD:  sized[n] = operand_t'(regs.gpr[n][15:0]);
                SIZE_DWORD: sized[n] = operand_t'(regs.gpr[n]);
                SIZE_MMX:   sized[n] = regs.mm[n];
                default:    sized[n] = '0;
            endcase
        end
    end

endmodule

//--- source/agen_pkg.sv
/*
 * Types and encodings shared by the address generation stage.
 * Real-mode addressing only, with no mod r/m and no segment limit check.
 */
package agen_pkg;

    localparam int NUM_REGS  = 8;
    localparam int SEG_SHIFT = 4;

    // string operand offset registers
    localparam int REG_ESI = 6;
    localparam int REG_EDI = 7;

    typedef logic [31:0] gpr_t;
    typedef logic [15:0] seg_t;
    typedef logic [63:0] mmx_t;
    typedef logic [63:0] operand_t;
    typedef logic [31:0] addr_t;
    typedef logic [47:0] imm_t;
    typedef logic [2:0]  reg_num_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  flag_sel_t;
    typedef logic [1:0]  stack_op_t;
    typedef logic [15:0] opcode_t;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_REG   = 3'd1,
        OP_SEG   = 3'd2,
        OP_MMX   = 3'd3,
        OP_MODRM = 3'd4,
        OP_IMM   = 3'd5,
        OP_MEM   = 3'd6,
        OP_SYS   = 3'd7
    } op_kind_t;

    // unnamed size codes select zero
    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3,
        SIZE_MMX   = 3'd5
    } op_size_t;

    typedef enum logic [2:0] {
        SEG_ES = 3'd0,
        SEG_CS = 3'd1,
        SEG_SS = 3'd2,
        SEG_DS = 3'd3,
        SEG_FS = 3'd4,
        SEG_GS = 3'd5
    } seg_idx_t;

    typedef struct packed {
        gpr_t [NUM_REGS-1:0] gpr;
        seg_t                es;
        seg_t                cs;
        seg_t                ss;
        seg_t                ds;
        seg_t                fs;
        seg_t                gs;
        mmx_t [NUM_REGS-1:0] mm;
    } reg_snapshot_t;

    // one size view per register number
    typedef operand_t [NUM_REGS-1:0] sized_regs_t;

    typedef struct packed {
        op_size_t  size;
        logic      set_d_flag;
        logic      clear_d_flag;
        op_kind_t  op0;
        op_kind_t  op1;
        reg_num_t  op0_reg;
        reg_num_t  op1_reg;
        imm_t      imm;
        alu_op_t   alu_op;
        flag_sel_t flag_0;
        flag_sel_t flag_1;
        stack_op_t stack_op;
        addr_t     stack_address;
        seg_idx_t  seg_override;
        logic      seg_override_valid;
        addr_t     pc;
        logic      branch_taken;
        opcode_t   opcode;
    } instr_ctrl_t;

    typedef struct packed {
        operand_t value;
        logic     is_reg;
        logic     is_segment;
        logic     is_mmx;
        logic     is_address;
    } op_result_t;

    typedef struct packed {
        op_size_t   size;
        logic       set_d_flag;
        logic       clear_d_flag;
        reg_num_t   op0_reg;
        reg_num_t   op1_reg;
        imm_t       imm;
        alu_op_t    alu_op;
        flag_sel_t  flag_0;
        flag_sel_t  flag_1;
        stack_op_t  stack_op;
        addr_t      stack_address;
        addr_t      pc;
        logic       branch_taken;
        opcode_t    opcode;
        op_result_t op0;
        op_result_t op1;
        logic       to_sys_controller;
    } agen_out_t;

    // indices 6 and 7 give zero
    function automatic seg_t seg_select(reg_snapshot_t regs, seg_idx_t idx);
        case (idx)
            SEG_ES:  return regs.es;
            SEG_CS:  return regs.cs;
            SEG_SS:  return regs.ss;
            SEG_DS:  return regs.ds;
            SEG_FS:  return regs.fs;
            SEG_GS:  return regs.gs;
            default: return '0;
        endcase
    endfunction

    // real-mode segment * 16 + offset that wraps at 32 bits
    function automatic addr_t real_mode_addr(seg_t seg, gpr_t offset);
        return (addr_t'(seg) << SEG_SHIFT) + offset;
    endfunction

endpackage
